/* dv/apply_tb.sv */
module apply_tb
	import bdd_pkg::*;
	import mem_pkg::*;
();

	localparam int NUM_REQ = 80;
	localparam int CYCLES_PER_REQ = 60; // Bound on memory delays per request
	localparam int TIMEOUT = (NUM_REQ * CYCLES_PER_REQ + 20) * 100;

	logic clk;
	logic reset;
	apply_req_t req;
	logic req_valid;
	logic req_busy;
	term_out_t term_out;
	logic term_valid;
	expand_out_t expand_out;
	logic expand_valid;
	logic expand_busy;
	var_mem_req_t var_req;
	logic var_req_valid;
	logic var_req_ready;
	var_mem_rsp_t var_rsp;
	logic var_rsp_valid;
	node_mem_req_t node_req;
	logic node_req_valid;
	logic node_busy;
	node_mem_rsp_t node_rsp;
	logic node_rsp_valid;
	logic [7:0] mem_rnd;

	logic [31:0] lfsr = 32'd79504;
	logic [7:0] in_flight = '0;
	logic exp_is_term [8];
	term_out_t exp_term [8];
	expand_out_t exp_expand [8];
	int acc_cycle [8];
	int cycle = 0;
	int sent = 0;
	int done_count = 0;
	int errors = 0;
	logic held_valid = 1'b0;
	expand_out_t held_rec;

	apply_front UUT (.*);

	apply_tb_mem u_mem (.clk(clk), .reset(reset), .rnd(mem_rnd), .var_req(var_req),
		.var_req_valid(var_req_valid), .var_req_ready(var_req_ready), .var_rsp(var_rsp),
		.var_rsp_valid(var_rsp_valid), .node_req(node_req), .node_req_valid(node_req_valid),
		.node_busy(node_busy), .node_rsp(node_rsp), .node_rsp_valid(node_rsp_valid));

	always #50 clk = ~clk;

	function automatic logic [15:0] take_bits(input int n);
		logic [15:0] bits;
		bits = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8000_0057) : (lfsr >> 1);
			bits = {bits[14:0], lfsr[0]};
		end
		return bits;
	endfunction

	// Terminals and nodes 1 to 6 so that hits and shared variables occur
	function automatic edge_t pick_operand();
		logic [15:0] sel;
		logic [15:0] comp;
		sel = take_bits(3);
		if (sel < 16'd2)
			return {29'd0, sel[0]};
		comp = take_bits(1);
		return {26'd0, sel[2:0] - 3'd1, comp[0]};
	endfunction

	function automatic logic term_rule(input apply_req_t r, output edge_t res);
		edge_t ident; // Neutral constant of the op
		edge_t absorb;
		res = EDGE_FALSE;
		if (r.op == XOR)
		begin
			if (r.f == r.g)
				return 1'b1;
			if (r.f == EDGE_FALSE || r.f == EDGE_TRUE)
				res = (r.f == EDGE_TRUE) ? (r.g ^ 30'd1) : r.g;
			else if (r.g == EDGE_FALSE || r.g == EDGE_TRUE)
				res = (r.g == EDGE_TRUE) ? (r.f ^ 30'd1) : r.f;
			else
				return 1'b0;
			return 1'b1;
		end
		ident = (r.op == AND) ? EDGE_TRUE : EDGE_FALSE;
		absorb = (r.op == AND) ? EDGE_FALSE : EDGE_TRUE;
		if (r.f == absorb || r.g == absorb)
			res = absorb;
		else if (r.f == ident)
			res = r.g;
		else if (r.g == ident || r.f == r.g)
			res = r.f;
		else
			return 1'b0;
		return 1'b1;
	endfunction

	function automatic expand_out_t expand_model(input apply_req_t r);
		expand_out_t e;
		var_t vf;
		var_t vg;
		e.exp.req = r;
		if (r.f > r.g)
		begin
			e.exp.req.f = r.g;
			e.exp.req.g = r.f;
		end
		vf = u_mem.var_table[e.exp.req.f[6:1]];
		vg = u_mem.var_table[e.exp.req.g[6:1]];
		e.exp.top = (vg < vf) ? vg : vf;
		e.exp.fetch_f = (vf == e.exp.top);
		e.exp.fetch_g = (vg == e.exp.top);
		e.fn = e.exp.req.f;
		e.fv = e.exp.req.f;
		e.gn = e.exp.req.g;
		e.gv = e.exp.req.g;
		if (e.exp.fetch_f)
		begin
			e.fn = u_mem.lo_table[e.exp.req.f[6:1]] ^ {29'd0, e.exp.req.f[0]};
			e.fv = u_mem.hi_table[e.exp.req.f[6:1]] ^ {29'd0, e.exp.req.f[0]};
		end
		if (e.exp.fetch_g)
		begin
			e.gn = u_mem.lo_table[e.exp.req.g[6:1]] ^ {29'd0, e.exp.req.g[0]};
			e.gv = u_mem.hi_table[e.exp.req.g[6:1]] ^ {29'd0, e.exp.req.g[0]};
		end
		return e;
	endfunction

	task automatic compare_term(input term_out_t got, input term_out_t exp);
		if (got !== exp)
		begin
			$display("[ERROR] %0t id %0d terminal result %h, expected %h", $time, got.id,
				got.result, exp.result);
			errors++;
		end
	endtask

	task automatic compare_expand(input expand_out_t got, input expand_out_t exp);
		if (got !== exp)
		begin
			$display("[ERROR] %0t id %0d expansion %h, expected %h", $time, got.exp.req.id,
				got, exp);
			errors++;
		end
	endtask

	task automatic finish_result(input req_id_t id, input logic is_term);
		if (!in_flight[id] || exp_is_term[id] != is_term)
		begin
			$display("[ERROR] %0t result for id %0d that is not in flight as this kind",
				$time, id);
			errors++;
		end
		in_flight[id] = 1'b0;
		done_count++;
		$display("Test %0d done: id %0d, %s", done_count, id, is_term ? "terminal" : "expand");
	endtask

	always @(posedge clk)
	begin
		logic [15:0] bits;
		logic [15:0] id_bits;
		edge_t res;
		if (!reset)
		begin
			cycle++;
			if (term_valid)
			begin
				if (cycle != acc_cycle[term_out.id] + 1)
				begin
					$display("[ERROR] %0t id %0d terminal latency wrong", $time, term_out.id);
					errors++;
				end
				compare_term(term_out, exp_term[term_out.id]);
				finish_result(term_out.id, 1'b1);
			end
			if (held_valid && (!expand_valid || expand_out !== held_rec))
			begin
				$display("[ERROR] %0t expansion record dropped or changed while stalled", $time);
				errors++;
			end
			held_valid = expand_valid & expand_busy;
			held_rec = expand_out;
			if (expand_valid && !expand_busy)
			begin
				compare_expand(expand_out, exp_expand[expand_out.exp.req.id]);
				finish_result(expand_out.exp.req.id, 1'b0);
			end
			if (req_valid && !req_busy)
			begin
				in_flight[req.id] = 1'b1;
				acc_cycle[req.id] = cycle;
				exp_is_term[req.id] = term_rule(req, res);
				exp_term[req.id] = '{id: req.id, result: res};
				exp_expand[req.id] = expand_model(req);
				sent++;
			end
			if (!req_valid || !req_busy)
			begin
				bits = take_bits(1);
				id_bits = take_bits(3);
				if (sent < NUM_REQ && bits[0] && !in_flight[id_bits[2:0]])
				begin
					bits = take_bits(2);
					req.id <= id_bits[2:0];
					req.op <= (bits[1:0] == 2'd3) ? AND : apply_op_t'(bits[1:0]);
					req.f <= pick_operand();
					req.g <= pick_operand();
					req_valid <= 1'b1;
				end
				else
					req_valid <= 1'b0;
			end
			bits = take_bits(1);
			expand_busy <= bits[0];
			bits = take_bits(8);
			mem_rnd <= bits[7:0];
		end
	end

	initial
	begin
		clk = 1'b0;
		reset = 1'b1;
		req = '0;
		req_valid = 1'b0;
		expand_busy = 1'b0;
		mem_rnd = '0;
		repeat (4) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		if (req_busy || term_valid || expand_valid || var_req_valid || node_req_valid)
		begin
			$display("[ERROR] %0t outputs not idle after reset", $time);
			errors++;
		end
		wait (done_count >= NUM_REQ);
		repeat (2) @(posedge clk);
		$display("Results: %0d requests, %0d done, %0d errors", sent, done_count, errors);
		if (errors == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

	// Watchdog
	initial
	begin
		#(TIMEOUT);
		$display("Timeout: only %0d of %0d results arrived", done_count, NUM_REQ);
		$display(">>> FAIL");
		$finish;
	end

endmodule

/* dv/apply_tb_mem.sv */
module apply_tb_mem
	import bdd_pkg::*;
	import mem_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic [7:0] rnd, // Random bits from the testbench that change each cycle

	input var_mem_req_t var_req,
	input logic var_req_valid,
	output logic var_req_ready,
	output var_mem_rsp_t var_rsp,
	output logic var_rsp_valid,

	input node_mem_req_t node_req,
	input logic node_req_valid,
	output logic node_busy,
	output node_mem_rsp_t node_rsp,
	output logic node_rsp_valid
);

	var_t var_table [0:63];
	edge_t hi_table [0:63];
	edge_t lo_table [0:63];
	var_t var_q [$]; // Pending variable responses in request order
	logic [1:0] var_cnt;
	node_mem_req_t node_held;
	logic node_pending;
	logic [1:0] node_cnt;

	initial
	begin
		var_req_ready = 1'b0; // Idle until the first clock edge
		var_rsp_valid = 1'b0;
		var_rsp = '0;
		node_busy = 1'b0;
		node_rsp_valid = 1'b0;
		node_rsp = '0;
		for (int i = 0; i < 64; i++)
		begin
			var_table[i] = 12'((i * 7) % 5); // Nodes five apart share a variable
			hi_table[i] = 30'(i * 37 + 5);
			lo_table[i] = 30'(i * 11 + 2);
		end
	end

	always @(posedge clk)
	begin
		if (reset)
		begin
			var_req_ready <= 1'b0;
			var_rsp_valid <= 1'b0;
			var_rsp <= '0;
			var_cnt <= 2'd0;
			var_q.delete();
			node_busy <= 1'b0;
			node_rsp_valid <= 1'b0;
			node_rsp <= '0;
			node_pending <= 1'b0;
			node_cnt <= 2'd0;
		end
		else
		begin
			var_rsp_valid <= 1'b0;
			if (var_q.size() > 0 && var_cnt == 2'd0)
			begin
				var_rsp <= var_q.pop_front();
				var_rsp_valid <= 1'b1;
				var_cnt <= rnd[1:0];
			end
			else if (var_q.size() > 0)
				var_cnt <= var_cnt - 2'd1;
			if (var_req_valid && var_req_ready)
				var_q.push_back(var_table[var_req[5:0]]);
			var_req_ready <= rnd[2] | rnd[3];

			node_rsp_valid <= 1'b0;
			if (node_pending && node_cnt == 2'd0)
			begin
				// Children that were not asked for come back as garbage
				node_rsp.f_hi <= node_held.fetch_f ? hi_table[node_held.f[6:1]] : '1;
				node_rsp.f_lo <= node_held.fetch_f ? lo_table[node_held.f[6:1]] : '1;
				node_rsp.g_hi <= node_held.fetch_g ? hi_table[node_held.g[6:1]] : '1;
				node_rsp.g_lo <= node_held.fetch_g ? lo_table[node_held.g[6:1]] : '1;
				node_rsp_valid <= 1'b1;
				node_pending <= 1'b0;
			end
			else if (node_pending)
				node_cnt <= node_cnt - 2'd1;
			if (node_req_valid && !node_busy)
			begin
				node_held <= node_req;
				node_pending <= 1'b1;
				node_cnt <= rnd[7:6];
			end
			node_busy <= rnd[4] & rnd[5];
		end
	end

endmodule

/* hw/apply_front.sv */
module apply_front
	import bdd_pkg::*;
	import mem_pkg::*;
(
	input logic clk,
	input logic reset,

	input apply_req_t req,
	input logic req_valid,
	output logic req_busy,

	output term_out_t term_out,
	output logic term_valid,

	output expand_out_t expand_out,
	output logic expand_valid,
	input logic expand_busy,

	output var_mem_req_t var_req,
	output logic var_req_valid,
	input logic var_req_ready,
	input var_mem_rsp_t var_rsp,
	input logic var_rsp_valid,

	output node_mem_req_t node_req,
	output logic node_req_valid,
	input logic node_busy,
	input node_mem_rsp_t node_rsp,
	input logic node_rsp_valid
);

	apply_req_t in_req;
	logic in_valid;
	logic check_busy;

	apply_req_t pass_req;
	logic pass_valid;
	logic pass_busy;

	apply_req_t fetch_req;
	logic fetch_valid;
	logic fetch_busy;

	expand_req_t exp_req;
	logic exp_valid;
	logic exp_busy;

	expand_req_t node_item;
	logic node_valid;
	logic node_fetch_busy;

	apply_stage_buffer #(.payload_t(apply_req_t)) buf_in (
		.clk(clk),
		.reset(reset),
		.valid_in(req_valid),
		.data_in(req),
		.busy(req_busy),
		.valid_out(in_valid),
		.data_out(in_req),
		.busy_in(check_busy)
	);

	// Terminal cases leave here, the rest go on ordered
	apply_terminal_check u_check (
		.req(in_req),
		.valid(in_valid),
		.busy(check_busy),
		.term_out(term_out),
		.term_valid(term_valid),
		.pass_req(pass_req),
		.pass_valid(pass_valid),
		.pass_busy(pass_busy)
	);

	apply_stage_buffer #(.payload_t(apply_req_t)) buf_var (
		.clk(clk),
		.reset(reset),
		.valid_in(pass_valid),
		.data_in(pass_req),
		.busy(pass_busy),
		.valid_out(fetch_valid),
		.data_out(fetch_req),
		.busy_in(fetch_busy)
	);

	apply_var_fetch u_var_fetch (
		.clk(clk),
		.reset(reset),
		.req(fetch_req),
		.valid(fetch_valid),
		.busy(fetch_busy),
		.var_req(var_req),
		.var_req_valid(var_req_valid),
		.var_req_ready(var_req_ready),
		.var_rsp(var_rsp),
		.var_rsp_valid(var_rsp_valid),
		.out(exp_req),
		.out_valid(exp_valid),
		.out_busy(exp_busy)
	);

	apply_stage_buffer #(.payload_t(expand_req_t)) buf_node (
		.clk(clk),
		.reset(reset),
		.valid_in(exp_valid),
		.data_in(exp_req),
		.busy(exp_busy),
		.valid_out(node_valid),
		.data_out(node_item),
		.busy_in(node_fetch_busy)
	);

	apply_node_fetch u_node_fetch (
		.clk(clk),
		.reset(reset),
		.req(node_item),
		.valid(node_valid),
		.busy(node_fetch_busy),
		.node_req(node_req),
		.node_req_valid(node_req_valid),
		.node_busy(node_busy),
		.node_rsp(node_rsp),
		.node_rsp_valid(node_rsp_valid),
		.expand_out(expand_out),
		.expand_valid(expand_valid),
		.expand_busy(expand_busy)
	);

endmodule

/* hw/apply_node_fetch.sv */
module apply_node_fetch
	import bdd_pkg::*;
	import mem_pkg::*;
(
	input logic clk,
	input logic reset,

	input expand_req_t req,
	input logic valid,
	output logic busy,

	// Node memory
	output node_mem_req_t node_req,
	output logic node_req_valid,
	input logic node_busy,
	input node_mem_rsp_t node_rsp,
	input logic node_rsp_valid,

	output expand_out_t expand_out,
	output logic expand_valid,
	input logic expand_busy
);

	typedef enum logic [1:0] {
		S_IDLE,
		S_WAIT,
		S_OUT
	} state_t;

	state_t state;
	state_t state_next;
	node_mem_rsp_t children;
	logic store;

	// Complement fix for a fetched operand, passthrough otherwise
	function automatic edge_t child_edge(edge_t stored, edge_t operand, logic fetched);
		if (fetched)
			return {stored[29:1], stored[0] ^ operand[0]};
		return operand;
	endfunction

	always_ff @(posedge clk)
	begin
		if (reset)
			state <= S_IDLE;
		else
			state <= state_next;
	end

	always_ff @(posedge clk)
	begin
		if (store)
			children <= node_rsp;
	end

	assign node_req.f = req.req.f;
	assign node_req.g = req.req.g;
	assign node_req.fetch_f = req.fetch_f;
	assign node_req.fetch_g = req.fetch_g;

	always_comb
	begin
		state_next = state;
		node_req_valid = 1'b0;
		store = 1'b0;
		expand_valid = 1'b0;
		case (state)
			S_IDLE:
			begin
				node_req_valid = valid;
				if (valid && !node_busy)
					state_next = S_WAIT;
			end
			S_WAIT:
			begin
				store = node_rsp_valid;
				if (node_rsp_valid)
					state_next = S_OUT;
			end
			S_OUT:
			begin
				expand_valid = 1'b1; // Held until the sink takes it
				if (!expand_busy)
					state_next = S_IDLE;
			end
			default:
			begin
				state_next = S_IDLE;
			end
		endcase
	end

	assign expand_out.exp = req;
	assign expand_out.fn = child_edge(children.f_lo, req.req.f, req.fetch_f);
	assign expand_out.fv = child_edge(children.f_hi, req.req.f, req.fetch_f);
	assign expand_out.gn = child_edge(children.g_lo, req.req.g, req.fetch_g);
	assign expand_out.gv = child_edge(children.g_hi, req.req.g, req.fetch_g);

	// Buffered item leaves when the record is taken
	assign busy = ~expand_valid | expand_busy;
endmodule

/* hw/apply_stage_buffer.sv */
module apply_stage_buffer #(
	parameter type payload_t = logic
) (
	input logic clk,
	input logic reset,

	// Upstream side
	input logic valid_in,
	input payload_t data_in,
	output logic busy,

	// Downstream side
	output logic valid_out,
	output payload_t data_out,
	input logic busy_in
);

	logic load;

	// Full and the downstream stage will not take the item this cycle
	assign busy = valid_out & busy_in;

	// Empty, or the held item leaves on this edge
	assign load = ~busy;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			valid_out <= 1'b0;
		end
		else if (load)
		begin
			valid_out <= valid_in;
		end
	end

	// Payload register
	always_ff @(posedge clk)
	begin
		if (load && valid_in)
		begin
			data_out <= data_in;
		end
	end

endmodule

/* hw/apply_terminal_check.sv */
module apply_terminal_check
	import bdd_pkg::*;
(
	input apply_req_t req,
	input logic valid,
	output logic busy,

	output term_out_t term_out,
	output logic term_valid,

	output apply_req_t pass_req,
	output logic pass_valid,
	input logic pass_busy
);

	logic hit;
	edge_t result;
	logic swap;

	always_comb
	begin
		hit = 1'b0;
		result = EDGE_FALSE;
		case (req.op)
			AND:
			begin
				hit = 1'b1;
				if (req.f == EDGE_FALSE || req.g == EDGE_FALSE)
					result = EDGE_FALSE;
				else if (req.f == EDGE_TRUE)
					result = req.g;
				else if (req.g == EDGE_TRUE || req.f == req.g)
					result = req.f;
				else
					hit = 1'b0;
			end
			OR:
			begin
				hit = 1'b1;
				if (req.f == EDGE_TRUE || req.g == EDGE_TRUE)
					result = EDGE_TRUE;
				else if (req.f == EDGE_FALSE)
					result = req.g;
				else if (req.g == EDGE_FALSE || req.f == req.g)
					result = req.f;
				else
					hit = 1'b0;
			end
			XOR:
			begin
				hit = 1'b1;
				if (req.f == req.g)
					result = EDGE_FALSE;
				else if (req.f == EDGE_FALSE)
					result = req.g;
				else if (req.g == EDGE_FALSE)
					result = req.f;
				else if (req.f == EDGE_TRUE)
					result = {req.g[29:1], ~req.g[0]}; // Negated g
				else if (req.g == EDGE_TRUE)
					result = {req.f[29:1], ~req.f[0]};
				else
					hit = 1'b0;
			end
			default:
			begin
				hit = 1'b0;
			end
		endcase
	end

	// Operations are commutative, so order the operands
	assign swap = req.f > req.g;

	always_comb
	begin
		pass_req = req;
		if (swap)
		begin
			pass_req.f = req.g;
			pass_req.g = req.f;
		end
	end

	assign term_out.id = req.id;
	assign term_out.result = result;
	assign term_valid = valid & hit;

	assign pass_valid = valid & ~hit;
	assign busy = ~hit & pass_busy; // A hit is consumed at once
endmodule

/* hw/apply_var_fetch.sv */
module apply_var_fetch
	import bdd_pkg::*;
	import mem_pkg::*;
(
	input logic clk,
	input logic reset,

	input apply_req_t req,
	input logic valid,
	output logic busy,

	// Variable memory
	output var_mem_req_t var_req,
	output logic var_req_valid,
	input logic var_req_ready,
	input var_mem_rsp_t var_rsp,
	input logic var_rsp_valid,

	output expand_req_t out,
	output logic out_valid,
	input logic out_busy
);

	typedef enum logic [2:0] {
		S_IDLE,
		S_SENT_F,    // f sent, g not yet sent
		S_SENT_BOTH, // Both sent, waiting for f
		S_GOT_F,     // f received, g not yet sent
		S_WAIT_G,
		S_DONE
	} state_t;

	state_t state;
	state_t state_next;
	var_t f_var;
	var_t g_var;
	var_t top;
	logic store_f;
	logic store_g;

	always_ff @(posedge clk)
	begin
		if (reset)
			state <= S_IDLE;
		else
			state <= state_next;
	end

	// Responses come back in request order, f first
	always_ff @(posedge clk)
	begin
		if (store_f)
			f_var <= var_rsp;
		if (store_g)
			g_var <= var_rsp;
	end

	always_comb
	begin
		state_next = state;
		var_req = req.g[29:1];
		var_req_valid = 1'b0;
		store_f = 1'b0;
		store_g = 1'b0;
		out_valid = 1'b0;
		case (state)
			S_IDLE:
			begin
				var_req = req.f[29:1];
				var_req_valid = valid;
				if (valid && var_req_ready)
					state_next = S_SENT_F;
			end
			S_SENT_F:
			begin
				var_req_valid = 1'b1; // g goes out while f is pending
				store_f = var_rsp_valid;
				if (var_rsp_valid && var_req_ready)
					state_next = S_WAIT_G;
				else if (var_rsp_valid)
					state_next = S_GOT_F;
				else if (var_req_ready)
					state_next = S_SENT_BOTH;
			end
			S_SENT_BOTH:
			begin
				store_f = var_rsp_valid;
				if (var_rsp_valid)
					state_next = S_WAIT_G;
			end
			S_GOT_F:
			begin
				var_req_valid = 1'b1;
				if (var_req_ready)
					state_next = S_WAIT_G;
			end
			S_WAIT_G:
			begin
				store_g = var_rsp_valid;
				if (var_rsp_valid)
					state_next = S_DONE;
			end
			S_DONE:
			begin
				out_valid = 1'b1;
				if (!out_busy)
					state_next = S_IDLE;
			end
			default:
			begin
				state_next = S_IDLE;
			end
		endcase
	end

	assign top = (f_var < g_var) ? f_var : g_var;

	assign out.req = req;
	assign out.top = top;
	assign out.fetch_f = (f_var == top);
	assign out.fetch_g = (g_var == top); // Both set on equal variables

	// Input item stays in the buffer until the result is taken
	assign busy = ~out_valid | out_busy;
endmodule

/* hw/bdd_pkg.sv */
package bdd_pkg;

	// Edge index, bit 0 is the complement flag and bits 29:1 the node number
	typedef logic [29:0] edge_t;

	// Node 0 is the constant terminal
	localparam edge_t EDGE_TRUE = 30'd0;
	localparam edge_t EDGE_FALSE = 30'd1;

	typedef logic [11:0] var_t; // Smaller number is nearer the root
	typedef logic [2:0] req_id_t;

	typedef enum logic [1:0] {
		AND = 2'd0,
		OR = 2'd1,
		XOR = 2'd2
	} apply_op_t;

	// Request as it enters the unit
	typedef struct packed {
		req_id_t id;
		apply_op_t op;
		edge_t f;
		edge_t g;
	} apply_req_t;

	typedef struct packed {
		apply_req_t req;
		var_t top;
		logic fetch_f;
		logic fetch_g;
	} expand_req_t;

	// Expansion record for the next unit
	typedef struct packed {
		expand_req_t exp;
		edge_t fn; // Low child of f
		edge_t fv; // High child of f
		edge_t gn;
		edge_t gv;
	} expand_out_t;

	typedef struct packed {
		req_id_t id;
		edge_t result;
	} term_out_t;

endpackage

/* hw/mem_pkg.sv */
package mem_pkg;

	import bdd_pkg::*;

	// Variable memory, indexed by node number
	typedef logic [28:0] var_mem_req_t;
	typedef var_t var_mem_rsp_t;

	// Node memory, fetches children of up to two nodes at once
	typedef struct packed {
		edge_t f;
		edge_t g;
		logic fetch_f;
		logic fetch_g;
	} node_mem_req_t;

	// Children as stored, without the operand's complement flag
	typedef struct packed {
		edge_t f_hi;
		edge_t f_lo;
		edge_t g_hi;
		edge_t g_lo;
	} node_mem_rsp_t;

endpackage

/* run.sh */
#!/bin/sh
# Compile and run the apply front end testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing -f src.f --top-module apply_tb -o apply_sim

./obj_dir/apply_sim > sim.log 2>&1 || true
cat sim.log

if grep -q ">>> PASS" sim.log; then
	exit 0
fi
exit 1

/* src.f */
hw/bdd_pkg.sv
hw/mem_pkg.sv
hw/apply_stage_buffer.sv
hw/apply_terminal_check.sv
hw/apply_var_fetch.sv
hw/apply_node_fetch.sv
hw/apply_front.sv
dv/apply_tb_mem.sv
dv/apply_tb.sv
